// ==== include/clink_bridge_consts.svh ====
`ifndef CLINK_BRIDGE_CONSTS_SVH
`define CLINK_BRIDGE_CONSTS_SVH

//////////////////////////////
// Bus widths
//////////////////////////////

`define CLB_ADDR_W 7    // Byte address into the register window
`define CLB_DATA_W 128
`define CLB_ID_W   16   // Transaction id, echoed on B and R

//////////////////////////////
// Register offsets
//////////////////////////////

// Write side
`define CLB_OFS_UART_TX   `CLB_ADDR_W'('h00)  // Byte to UART transmitter
`define CLB_OFS_CC        `CLB_ADDR_W'('h10)  // Camera control lines
`define CLB_OFS_CLINK_RST `CLB_ADDR_W'('h20)
`define CLB_OFS_DRAM_RST  `CLB_ADDR_W'('h30)

// Read side, sharing the low offsets with writes
`define CLB_OFS_UART_RX   `CLB_ADDR_W'('h00)  // Clears the byte on read
`define CLB_OFS_RX_VALID  `CLB_ADDR_W'('h20)
`define CLB_OFS_TX_BUSY   `CLB_ADDR_W'('h30)

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the camera-link bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f sim.f --top-module tb_clink_axi_bridge -o tb_sim

# The pipe keeps the log even when the simulation stops early
./obj_dir/tb_sim | tee sim.log

if grep -qx "Testbench passed" sim.log; then
    echo "Simulation result: pass"
else
    echo "Simulation result: fail"
    exit 1
fi

// ==== sim.f ====
+incdir+include
source/axi_slave_pkg.sv
source/clink_regs_pkg.sv
source/axi_write_decoder.sv
source/axi_read_responder.sv
source/clink_axi_bridge.sv
testbench/clink_bridge_chk.sv
testbench/tb_clink_axi_bridge.sv

// ==== source/axi_read_responder.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "clink_bridge_consts.svh"

module axi_read_responder
    import axi_slave_pkg::*;
    import clink_regs_pkg::*;
(
    input  wire             s_axi_aclk,
    input  wire             s_axi_aresetn,

    // Read address
    input  wire axi_addr_t  araddr,
    input  wire axi_id_t    arid,
    input  wire             arvalid,
    output logic            arready,

    // Read data, always a single beat
    input  wire             rready,
    output axi_data_t       rdata,
    output axi_resp_t       rresp,
    output logic            rvalid,
    output logic            rlast,
    output axi_id_t         rid,

    // UART status from the board
    input  wire             rx_ready,
    input  wire uart_byte_t rx_data,
    input  wire             tx_busy
);

    rd_source_t state;
    axi_id_t    id_q;

    uart_byte_t rx_byte;    // Last received byte
    logic       rx_valid;
    logic       rx_clear;   // Pulses with rvalid of a byte read

    axi_data_t  rd_value;
    logic       rd_go;      // Response is issued at this edge

    function automatic rd_source_t decode_source(input axi_addr_t addr);
        rd_source_t source;
        case (addr)
            `CLB_OFS_UART_RX:  source = rd_uart_rx;
            `CLB_OFS_RX_VALID: source = rd_rx_valid;
            `CLB_OFS_TX_BUSY:  source = rd_tx_busy;
            default:           source = rd_error;
        endcase
        return source;
    endfunction

    //////////////////////////////
    // Receive holding register
    //////////////////////////////

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            rx_byte  <= 8'h00;
            rx_valid <= 1'b0;
        end else if (rx_clear) begin    // Clear beats a new byte
            rx_byte  <= 8'h00;
            rx_valid <= 1'b0;
        end else if (rx_ready) begin
            rx_byte  <= rx_data;
            rx_valid <= 1'b1;
        end
    end

    //////////////////////////////
    // Read FSM
    //////////////////////////////

    assign arready = (state == rd_idle);

    always_comb begin
        rd_value = '0;
        rd_go    = 1'b0;
        case (state)
            rd_uart_rx: begin
                rd_value = axi_data_t'(rx_byte);
                rd_go    = rready && rx_valid;  // Waits for a byte
            end
            rd_rx_valid: begin
                rd_value = axi_data_t'(rx_valid);
                rd_go    = rready;
            end
            rd_tx_busy: begin
                rd_value = axi_data_t'(tx_busy);
                rd_go    = rready;
            end
            rd_error: rd_go = 1'b1;     // Regardless of rready
            default: ;
        endcase
    end

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state    <= rd_idle;
            rvalid   <= 1'b0;
            rlast    <= 1'b0;
            rx_clear <= 1'b0;
        end else begin
            rvalid   <= rd_go;
            rlast    <= rd_go;
            rx_clear <= rd_go && (state == rd_uart_rx);
            if (state == rd_idle) begin
                if (arvalid) begin
                    state <= decode_source(araddr);
                end
            end else if (rd_go) begin
                state <= rd_idle;
            end
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (arready && arvalid) begin
            id_q <= arid;
        end
        if (rd_go) begin
            rdata <= rd_value;
            rid   <= id_q;
            rresp <= (state == rd_error) ? RESP_SLVERR : RESP_OKAY;
        end
    end

endmodule

`default_nettype wire

// ==== source/axi_slave_pkg.sv ====
`default_nettype none

`include "clink_bridge_consts.svh"

package axi_slave_pkg;

    //////////////////////////////
    // AXI4 slave side types
    //////////////////////////////

    // Only the two codes this slave ever returns
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_t;

    typedef logic [`CLB_ID_W-1:0]   axi_id_t;   // Echoed on bid and rid
    typedef logic [`CLB_ADDR_W-1:0] axi_addr_t;
    typedef logic [`CLB_DATA_W-1:0] axi_data_t; // Full beat, narrow values zero-extended

endpackage

`default_nettype wire

// ==== source/axi_write_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "clink_bridge_consts.svh"

module axi_write_decoder
    import axi_slave_pkg::*;
    import clink_regs_pkg::*;
(
    input  wire             s_axi_aclk,
    input  wire             s_axi_aresetn,

    // Write address
    input  wire axi_addr_t  awaddr,
    input  wire axi_id_t    awid,
    input  wire             awvalid,
    output logic            awready,

    // Write data
    input  wire axi_data_t  wdata,
    input  wire             wvalid,
    input  wire             wlast,
    output logic            wready,

    // Write response
    input  wire             bready,
    output axi_resp_t       bresp,
    output logic            bvalid,
    output axi_id_t         bid,

    // Camera-link board side
    output logic            tx_start,
    output uart_byte_t      tx_data,
    output logic [3:0]      cc,
    output logic            clink_resetn,   // Active low
    output logic            dram_resetn     // Active low
);

    wr_target_t state;
    axi_id_t    id_q;       // Id of the burst in flight

    logic aw_fire;
    logic w_beat;
    logic w_last_beat;
    logic b_fire;

    // Map an offset onto its target state
    function automatic wr_target_t decode_target(input axi_addr_t addr);
        wr_target_t target;
        case (addr)
            `CLB_OFS_UART_TX:   target = wr_uart_tx;
            `CLB_OFS_CC:        target = wr_cc;
            `CLB_OFS_CLINK_RST: target = wr_clink_rst;
            `CLB_OFS_DRAM_RST:  target = wr_dram_rst;
            default:            target = wr_error;
        endcase
        return target;
    endfunction

    //////////////////////////////
    // Handshakes
    //////////////////////////////

    assign awready = (state == wr_idle);
    assign wready  = (state == wr_uart_tx) || (state == wr_cc) ||
                     (state == wr_clink_rst) || (state == wr_dram_rst);

    assign aw_fire     = awready && awvalid;
    assign w_beat      = wready && wvalid;
    assign w_last_beat = w_beat && wlast;
    assign b_fire      = ((state == wr_error) || (state == wr_response)) && bready;

    //////////////////////////////
    // FSM and output registers
    //////////////////////////////

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state        <= wr_idle;
            bvalid       <= 1'b0;
            tx_start     <= 1'b0;
            cc           <= 4'h0;
            clink_resetn <= 1'b1;
            dram_resetn  <= 1'b1;
        end else begin
            tx_start <= 1'b0;   // One cycle per beat
            bvalid   <= 1'b0;
            case (state)
                wr_idle: begin
                    if (aw_fire) begin
                        state <= decode_target(awaddr);
                    end
                end
                wr_uart_tx: begin
                    if (w_beat) begin
                        tx_start <= 1'b1;
                    end
                end
                wr_cc: begin
                    if (w_beat) begin
                        cc <= wdata[3:0];
                    end
                end
                wr_clink_rst: begin
                    if (w_beat) begin
                        clink_resetn <= ~wdata[0];  // Writing 1 asserts the reset
                    end
                end
                wr_dram_rst: begin
                    if (w_beat) begin
                        dram_resetn <= ~wdata[0];
                    end
                end
                wr_error, wr_response: begin
                    if (b_fire) begin
                        bvalid <= 1'b1;
                        state  <= wr_idle;
                    end
                end
                default: state <= wr_idle;
            endcase

            // Burst ends on wlast whatever the target
            if (w_last_beat) begin
                state <= wr_response;
            end
        end
    end

    // Payload, no reset needed
    always_ff @(posedge s_axi_aclk) begin
        if (aw_fire) begin
            id_q <= awid;
        end
        if ((state == wr_uart_tx) && w_beat) begin
            tx_data <= wdata[7:0];
        end
        if (b_fire) begin
            bid   <= id_q;
            bresp <= (state == wr_error) ? RESP_SLVERR : RESP_OKAY;
        end
    end

endmodule

`default_nettype wire

// ==== source/clink_axi_bridge.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "clink_bridge_consts.svh"

module clink_axi_bridge (
    input  wire                     s_axi_aclk,
    input  wire                     s_axi_aresetn,

    //////////////////////////////
    // AXI4 write channels
    //////////////////////////////
    input  wire [`CLB_ADDR_W-1:0]   s_axi_awaddr,
    input  wire [`CLB_ID_W-1:0]     s_axi_awid,
    input  wire                     s_axi_awvalid,
    output logic                    s_axi_awready,
    input  wire [`CLB_DATA_W-1:0]   s_axi_wdata,
    input  wire                     s_axi_wvalid,
    input  wire                     s_axi_wlast,
    output logic                    s_axi_wready,
    input  wire                     s_axi_bready,
    output logic [1:0]              s_axi_bresp,
    output logic                    s_axi_bvalid,
    output logic [`CLB_ID_W-1:0]    s_axi_bid,

    //////////////////////////////
    // AXI4 read channels
    //////////////////////////////
    input  wire [`CLB_ADDR_W-1:0]   s_axi_araddr,
    input  wire [`CLB_ID_W-1:0]     s_axi_arid,
    input  wire                     s_axi_arvalid,
    output logic                    s_axi_arready,
    input  wire                     s_axi_rready,
    output logic [`CLB_DATA_W-1:0]  s_axi_rdata,
    output logic [1:0]              s_axi_rresp,
    output logic                    s_axi_rvalid,
    output logic                    s_axi_rlast,
    output logic [`CLB_ID_W-1:0]    s_axi_rid,

    // Camera-link board
    output logic                    tx_start,
    output logic [7:0]              tx_data,
    input  wire                     tx_busy,
    input  wire                     rx_ready,
    input  wire [7:0]               rx_data,
    output logic [3:0]              cc,
    output logic                    clink_resetn,
    output logic                    dram_resetn
);

    // Write side owns the UART transmit and control outputs
    axi_write_decoder wr0 (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .awaddr        (s_axi_awaddr),
        .awid          (s_axi_awid),
        .awvalid       (s_axi_awvalid),
        .awready       (s_axi_awready),
        .wdata         (s_axi_wdata),
        .wvalid        (s_axi_wvalid),
        .wlast         (s_axi_wlast),
        .wready        (s_axi_wready),
        .bready        (s_axi_bready),
        .bresp         (s_axi_bresp),
        .bvalid        (s_axi_bvalid),
        .bid           (s_axi_bid),
        .tx_start      (tx_start),
        .tx_data       (tx_data),
        .cc            (cc),
        .clink_resetn  (clink_resetn),
        .dram_resetn   (dram_resetn)
    );

    // Read side holds the receive byte
    axi_read_responder rd0 (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .araddr        (s_axi_araddr),
        .arid          (s_axi_arid),
        .arvalid       (s_axi_arvalid),
        .arready       (s_axi_arready),
        .rready        (s_axi_rready),
        .rdata         (s_axi_rdata),
        .rresp         (s_axi_rresp),
        .rvalid        (s_axi_rvalid),
        .rlast         (s_axi_rlast),
        .rid           (s_axi_rid),
        .rx_ready      (rx_ready),
        .rx_data       (rx_data),
        .tx_busy       (tx_busy)
    );

endmodule

`default_nettype wire

// ==== source/clink_regs_pkg.sv ====
`default_nettype none

package clink_regs_pkg;

    //////////////////////////////
    // Register map types
    //////////////////////////////

    // Write decoder states, one per write target
    typedef enum logic [2:0] {
        wr_idle,
        wr_uart_tx,
        wr_cc,
        wr_clink_rst,
        wr_dram_rst,
        wr_error,       // Unmapped offset, no data accepted
        wr_response
    } wr_target_t;

    // Read responder states, one per read source
    typedef enum logic [2:0] {
        rd_idle,
        rd_uart_rx,
        rd_rx_valid,
        rd_tx_busy,
        rd_error
    } rd_source_t;

    typedef logic [7:0] uart_byte_t;

endpackage

`default_nettype wire

// ==== testbench/clink_bridge_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

module clink_bridge_chk (
    input wire s_axi_aclk,
    input wire s_axi_aresetn,
    input wire bvalid,
    input wire rvalid,
    input wire rlast,
    input wire tx_start,
    input wire wvalid,
    input wire awready
);

    // Write response is a single-cycle pulse
    bvalid_pulse: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        bvalid |=> !bvalid)
        else $error("bvalid held high for more than one cycle");

    rvalid_pulse: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        rvalid |-> rlast ##1 !rvalid)
        else $error("rvalid not a single-beat pulse with rlast");

    // Back-to-back pulses only come from back-to-back beats
    tx_start_beats: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        tx_start && $past(tx_start) |-> $past(wvalid) && $past(wvalid, 2))
        else $error("tx_start high on two cycles without held wvalid");

    // Address channel stays closed until the write response
    aw_reopen_with_b: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        $rose(awready) |-> bvalid)
        else $error("awready returned without a write response");

endmodule

bind clink_axi_bridge clink_bridge_chk chk0 (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .bvalid        (s_axi_bvalid),
    .rvalid        (s_axi_rvalid),
    .rlast         (s_axi_rlast),
    .tx_start      (tx_start),
    .wvalid        (s_axi_wvalid),
    .awready       (s_axi_awready)
);

`default_nettype wire

// ==== testbench/tb_clink_axi_bridge.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "clink_bridge_consts.svh"

module tb_clink_axi_bridge
    import axi_slave_pkg::*;
();

    localparam int RESP_LIMIT = 50;                 // Cycles to wait for any response
    localparam int N_TRANS    = 20;                 // Transactions in the whole run
    localparam int TIMEOUT_NS = N_TRANS * 100 * 10; // Up to 100 cycles of 10 ns each

    typedef struct packed {
        axi_resp_t  resp;
        axi_id_t    id;
        logic [3:0] cc;
        logic       clink_resetn;
        logic       dram_resetn;
    } wr_expect_t;

    typedef struct packed {
        axi_data_t data;
        axi_resp_t resp;
        axi_id_t   id;
    } rd_expect_t;

    logic       s_axi_aclk;
    logic       s_axi_aresetn;
    axi_addr_t  s_axi_awaddr;
    axi_id_t    s_axi_awid;
    logic       s_axi_awvalid;
    logic       s_axi_awready;
    axi_data_t  s_axi_wdata;
    logic       s_axi_wvalid;
    logic       s_axi_wlast;
    logic       s_axi_wready;
    logic       s_axi_bready;
    logic [1:0] s_axi_bresp;
    logic       s_axi_bvalid;
    axi_id_t    s_axi_bid;
    axi_addr_t  s_axi_araddr;
    axi_id_t    s_axi_arid;
    logic       s_axi_arvalid;
    logic       s_axi_arready;
    logic       s_axi_rready;
    axi_data_t  s_axi_rdata;
    logic [1:0] s_axi_rresp;
    logic       s_axi_rvalid;
    logic       s_axi_rlast;
    axi_id_t    s_axi_rid;
    logic       tx_start;
    logic [7:0] tx_data;
    logic       tx_busy;
    logic       rx_ready;
    logic [7:0] rx_data;
    logic [3:0] cc;
    logic       clink_resetn;
    logic       dram_resetn;

    wr_expect_t exp_b[$];
    rd_expect_t exp_r[$];
    logic [7:0] exp_tx[$];     // One byte per UART beat
    wr_expect_t model;
    logic [31:0] lfsr = 32'd77045;
    int errors = 0;
    int checks = 0;
    int tests  = 0;

    clink_axi_bridge dut0 (.*);

    initial begin
        s_axi_aclk = 1'b0;
        forever #5 s_axi_aclk = ~s_axi_aclk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns, the run did not finish", TIMEOUT_NS);
        $display("Testbench failed");
        $finish;
    end

    //////////////////////////////
    // Helpers and reference model
    //////////////////////////////

    task automatic tick();
        @(posedge s_axi_aclk);
        #1;
    endtask

    // Galois form, right shift
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output axi_data_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[`CLB_DATA_W-2:0], lfsr[0]};
        end
    endtask

    // Output state and response after one beat to an offset
    function automatic wr_expect_t model_write(input wr_expect_t prev, input axi_addr_t addr,
                                               input axi_data_t data);
        wr_expect_t next;
        next      = prev;
        next.resp = RESP_OKAY;
        case (addr)
            `CLB_OFS_UART_TX:   ;                       // Only the byte on tx_data
            `CLB_OFS_CC:        next.cc = data[3:0];
            `CLB_OFS_CLINK_RST: next.clink_resetn = ~data[0];
            `CLB_OFS_DRAM_RST:  next.dram_resetn = ~data[0];
            default:            next.resp = RESP_SLVERR; // Nothing changes
        endcase
        return next;
    endfunction

    task automatic report_test(input string name, input int err_at_start);
        tests++;
        $display("test %-14s %s", name, (errors == err_at_start) ? "ok" : "FAILED");
    endtask

    //////////////////////////////
    // Bus transactions
    //////////////////////////////

    task automatic axi_write(input axi_addr_t addr, input int nbeats, input logic rand_data,
                             input axi_data_t fixed_data, input int stall);
        axi_data_t  d;
        axi_data_t  id_bits;
        wr_expect_t want;
        int         waited;
        take_bits(`CLB_ID_W, id_bits);
        s_axi_awaddr  = addr;
        s_axi_awid    = id_bits[`CLB_ID_W-1:0];
        s_axi_awvalid = 1'b1;
        while (!s_axi_awready) tick();
        tick();
        s_axi_awvalid = 1'b0;
        want = model_write(model, addr, fixed_data);
        if (want.resp == RESP_OKAY) begin
            for (int i = 0; i < nbeats; i++) begin
                d = fixed_data;
                if (rand_data) take_bits(`CLB_DATA_W, d);
                if (!s_axi_wready) begin
                    errors++;
                    $display("ERROR %0t: wready low during a burst", $time);
                end
                s_axi_wdata  = d;
                s_axi_wvalid = 1'b1;
                s_axi_wlast  = (i == nbeats - 1);
                want  = model_write(model, addr, d);
                model = want;
                if (addr == `CLB_OFS_UART_TX) exp_tx.push_back(d[7:0]);
                tick();
            end
            s_axi_wvalid = 1'b0;
            s_axi_wlast  = 1'b0;
        end else if (s_axi_wready) begin
            errors++;
            $display("ERROR %0t: wready high for an unmapped write", $time);
        end
        want.id = s_axi_awid;
        exp_b.push_back(want);
        if (stall > 0) begin    // Master holds off the response
            s_axi_bready = 1'b0;
            repeat (stall) begin
                tick();
                if (s_axi_bvalid) begin
                    errors++;
                    $display("ERROR %0t: bvalid raised while bready was low", $time);
                end
            end
            s_axi_bready = 1'b1;
        end
        waited = 0;
        while (!s_axi_bvalid && waited < RESP_LIMIT) begin
            tick();
            waited++;
        end
        if (!s_axi_bvalid) begin
            errors++;
            $display("No write response within %0d cycles at %0t ns", RESP_LIMIT, $time);
        end else if (stall > 0 && waited != 1) begin
            errors++;
            $display("ERROR %0t: bvalid came %0d cycles after bready, not 1", $time, waited);
        end
        tick();     // Compare process sees the response first
    endtask

    task automatic axi_read(input axi_addr_t addr, input logic ready, input axi_data_t data,
                            input axi_resp_t resp, output int lat);
        axi_data_t  id_bits;
        rd_expect_t want;
        take_bits(`CLB_ID_W, id_bits);
        want.data = data;
        want.resp = resp;
        want.id   = id_bits[`CLB_ID_W-1:0];
        exp_r.push_back(want);
        s_axi_araddr  = addr;
        s_axi_arid    = want.id;
        s_axi_arvalid = 1'b1;
        s_axi_rready  = ready;
        while (!s_axi_arready) tick();
        tick();     // Accepted at this edge
        lat = 1;
        s_axi_arvalid = 1'b0;
        while (!s_axi_rvalid && lat < RESP_LIMIT) begin
            tick();
            lat++;
        end
        if (!s_axi_rvalid) begin
            errors++;
            $display("No read response within %0d cycles at %0t ns", RESP_LIMIT, $time);
        end
        tick();
        s_axi_rready = 1'b1;
    endtask

    //////////////////////////////
    // Response comparison
    //////////////////////////////

    always @(negedge s_axi_aclk) begin
        wr_expect_t eb;
        rd_expect_t er;
        if (s_axi_aresetn && s_axi_bvalid) begin
            checks++;
            if (exp_b.size() == 0) begin
                errors++;
                $display("Write response at %0t ns that no write asked for", $time);
            end else begin
                eb = exp_b.pop_front();
                if (s_axi_bresp !== eb.resp || s_axi_bid !== eb.id) begin
                    errors++;
                    $display("ERROR %0t: bresp %0d bid %h, expected %0d %h", $time,
                             s_axi_bresp, s_axi_bid, eb.resp, eb.id);
                end
                if ({cc, clink_resetn, dram_resetn} !== {eb.cc, eb.clink_resetn,
                                                         eb.dram_resetn}) begin
                    errors++;
                    $display("ERROR %0t: cc %h resets %b%b, expected %h %b%b", $time, cc,
                             clink_resetn, dram_resetn, eb.cc, eb.clink_resetn, eb.dram_resetn);
                end
            end
        end
        if (s_axi_aresetn && s_axi_rvalid) begin
            checks++;
            if (exp_r.size() == 0) begin
                errors++;
                $display("Read response at %0t ns that no read asked for", $time);
            end else begin
                er = exp_r.pop_front();
                if (s_axi_rdata !== er.data || s_axi_rresp !== er.resp ||
                    s_axi_rid !== er.id || s_axi_rlast !== 1'b1) begin
                    errors++;
                    $display("ERROR %0t: rdata %h rresp %0d rid %h, expected %h %0d %h", $time,
                             s_axi_rdata, s_axi_rresp, s_axi_rid, er.data, er.resp, er.id);
                end
            end
        end
        if (s_axi_aresetn && tx_start) begin
            checks++;
            if (exp_tx.size() == 0) begin
                errors++;
                $display("tx_start pulse at %0t ns without a UART beat", $time);
            end else if (tx_data !== exp_tx.pop_front()) begin
                errors++;
                $display("ERROR %0t: tx_data %h does not match the beat", $time, tx_data);
            end
        end
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        axi_data_t d;
        int        nb;
        int        lat;
        int        err0;
        s_axi_aresetn = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awid    = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_wlast   = 1'b0;
        s_axi_bready  = 1'b1;
        s_axi_araddr  = '0;
        s_axi_arid    = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b1;
        tx_busy       = 1'b0;
        rx_ready      = 1'b0;
        rx_data       = 8'h00;
        model = '{resp: RESP_OKAY, id: '0, cc: 4'h0, clink_resetn: 1'b1, dram_resetn: 1'b1};
        repeat (4) @(posedge s_axi_aclk);
        #1 s_axi_aresetn = 1'b1;

        err0 = errors;
        checks++;
        if ({tx_start, s_axi_bvalid, s_axi_rvalid, cc, clink_resetn, dram_resetn,
             s_axi_awready, s_axi_arready} !== {3'b000, 4'h0, 4'b1111}) begin
            errors++;
            $display("ERROR %0t: outputs not at their reset values", $time);
        end
        report_test("reset values", err0);

        err0 = errors;
        take_bits(2, d);
        nb = int'(d[1:0]) + 1;
        axi_write(`CLB_OFS_UART_TX, nb, 1'b1, '0, 0);
        if (exp_tx.size() != 0) begin
            errors++;
            $display("%0d UART beats gave no tx_start pulse", exp_tx.size());
        end
        report_test("uart burst", err0);

        err0 = errors;
        take_bits(2, d);
        axi_write(`CLB_OFS_CC, int'(d[1:0]) + 1, 1'b1, '0, 2);
        axi_write(`CLB_OFS_CLINK_RST, 1, 1'b0, axi_data_t'(1), 0);
        axi_write(`CLB_OFS_CLINK_RST, 1, 1'b0, '0, 0);
        axi_write(`CLB_OFS_DRAM_RST, 1, 1'b0, axi_data_t'(1), 0);
        axi_write(`CLB_OFS_DRAM_RST, 1, 1'b0, '0, 0);
        report_test("cc and resets", err0);

        err0 = errors;
        axi_write(`CLB_ADDR_W'('h40), 1, 1'b0, '0, 3);
        report_test("unmapped write", err0);

        err0 = errors;
        axi_read(`CLB_OFS_RX_VALID, 1'b1, '0, RESP_OKAY, lat);
        take_bits(8, d);
        rx_data  = d[7:0];
        rx_ready = 1'b1;
        tick();
        rx_ready = 1'b0;
        axi_read(`CLB_OFS_RX_VALID, 1'b1, axi_data_t'(1), RESP_OKAY, lat);
        axi_read(`CLB_OFS_UART_RX, 1'b1, axi_data_t'(d[7:0]), RESP_OKAY, lat);
        axi_read(`CLB_OFS_RX_VALID, 1'b1, '0, RESP_OKAY, lat);  // Cleared by the byte read
        report_test("uart receive", err0);

        err0 = errors;
        tx_busy = 1'b1;
        axi_read(`CLB_OFS_TX_BUSY, 1'b1, axi_data_t'(1), RESP_OKAY, lat);
        tx_busy = 1'b0;
        axi_read(`CLB_OFS_TX_BUSY, 1'b1, '0, RESP_OKAY, lat);
        axi_read(`CLB_ADDR_W'('h50), 1'b0, '0, RESP_SLVERR, lat);  // rready low on purpose
        checks++;
        if (lat != 2) begin
            errors++;
            $display("ERROR %0t: unmapped read gave rvalid after %0d cycles, not 2", $time, lat);
        end
        report_test("busy, unmapped", err0);

        if (exp_b.size() + exp_r.size() + exp_tx.size() != 0) begin
            errors++;
            $display("Expected responses never arrived");
        end
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
